//--- build.f
hw/rv64_pkg.sv
hw/rv_regfile.sv
hw/rv_decode.sv
hw/rv_alu.sv
hw/rv_mem_stage.sv
hw/rv_exec_pipe.sv
verification/tb_exec_pipe.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_exec_pipe -f build.f -o tb_exec_pipe

out="$(./obj_dir/tb_exec_pipe)"
echo "$out"

if echo "$out" | grep -qx "TEST OK"; then
    exit 0
else
    exit 1
fi

//--- verification/tb_exec_pipe.sv
`timescale 1ns/100ps

module tb_exec_pipe
    import rv64_pkg::*;
();

    localparam int NUM_SLOTS  = 600;
    localparam int DMEM_BYTES = 512;

    logic        CLK = 1'b0;
    logic        rst_n_i;
    logic        inst_valid_i;
    logic [31:0] inst_i;
    logic [63:0] pc_i;
    logic        wb_en_o;
    logic [4:0]  wb_rd_o;
    logic [63:0] wb_data_o;
    logic        redirect_o;
    logic [63:0] redirect_pc_o;

    // architectural model
    logic [63:0] xreg [32];
    logic [7:0]  mem_bytes [DMEM_BYTES];
    logic [4:0]  recent_rd [3];
    logic [4:0]  exp_rd [$];
    logic [63:0] exp_data [$];
    logic [63:0] exp_redirect [$];
    logic [31:0] rng;
    logic [63:0] pc;
    int          squash_left;
    int          checks;
    int          mismatches;
    int          failures;

    rv_exec_pipe #(
        .DMEM_WORDS(64)
    ) UUT (
        .CLK(CLK), .rst_n_i(rst_n_i), .inst_valid_i(inst_valid_i),
        .inst_i(inst_i), .pc_i(pc_i),
        .wb_en_o(wb_en_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o),
        .redirect_o(redirect_o), .redirect_pc_o(redirect_pc_o)
    );

    always #50 CLK = ~CLK;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function logic [31:0] rand32();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // avoid destinations of the last three slots
    function logic [4:0] pick_src();
        logic [31:0] t;
        for (int n = 0; n < 6; n++) begin
            t = rand32();
            if (t[4:0] == 5'd0 || (t[4:0] != recent_rd[0] && t[4:0] != recent_rd[1]
                    && t[4:0] != recent_rd[2])) begin
                return t[4:0];
            end
        end
        return 5'd0;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    function automatic logic [31:0] make_store(input logic [2:0] f3, input logic [4:0] rs2,
                                               input logic [8:0] addr);
        inst_u w;
        w = '0;
        w.s.opcode = OPC_STORE;
        w.s.funct3 = f3;
        w.s.rs2 = rs2;
        w.s.imm_hi = {3'd0, addr[8:5]};
        w.s.imm_lo = addr[4:0];
        return w;
    endfunction

    function automatic logic [63:0] alu_model(input inst_u w, input logic [63:0] a,
                                              input logic [63:0] b);
        logic               word;
        logic               reg_op;
        logic               alt;
        logic [5:0]         sh;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [31:0] sa32;
        logic [63:0]        r;
        word = w.r.opcode == OPC_OP_32 || w.r.opcode == OPC_OP_IMM_32;
        reg_op = w.r.opcode == OPC_OP || w.r.opcode == OPC_OP_32;
        alt = w.r.funct7[5];
        sh = word ? {1'b0, b[4:0]} : b[5:0];
        sa = a;
        sb = b;
        sa32 = a[31:0];
        case (w.r.funct3)
            3'd0:    r = (reg_op && alt) ? a - b : a + b;
            3'd1:    r = a << sh;
            3'd2:    r = {63'd0, sa < sb};
            3'd3:    r = {63'd0, a < b};
            3'd4:    r = a ^ b;
            3'd5: begin
                if (word && alt) begin
                    r = {32'd0, sa32 >>> sh};
                end else if (word) begin
                    r = {32'd0, a[31:0] >> sh};
                end else if (alt) begin
                    r = sa >>> sh;
                end else begin
                    r = a >> sh;
                end
            end
            3'd6:    r = a | b;
            default: r = a & b;
        endcase
        if (word) begin
            r = {{32{r[31]}}, r[31:0]};
        end
        return r;
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [63:0] a,
                                          input logic [63:0] b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            F3_BGE:  return $signed(a) >= $signed(b);
            F3_BLTU: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // little-endian bytes with the upper funct3 bit selecting zero extension
    function automatic logic [63:0] load_model(input logic [8:0] addr, input logic [2:0] f3);
        logic [63:0] v;
        int          size;
        size = 1 << f3[1:0];
        v = 64'd0;
        for (int i = size - 1; i >= 0; i--) begin
            v = (v << 8) | {56'd0, mem_bytes[addr + 9'(i)]};
        end
        if (!f3[2]) begin
            case (f3[1:0])
                2'd0:    v = {{56{v[7]}}, v[7:0]};
                2'd1:    v = {{48{v[15]}}, v[15:0]};
                2'd2:    v = {{32{v[31]}}, v[31:0]};
                default: v = v;
            endcase
        end
        return v;
    endfunction

    task automatic store_model(input logic [8:0] addr, input logic [2:0] f3,
                               input logic [63:0] val);
        logic [63:0] v;
        v = val;
        for (int i = 0; i < (1 << f3[1:0]); i++) begin
            mem_bytes[addr + 9'(i)] = v[7:0];
            v = v >> 8;
        end
    endtask

    task automatic expect_write(input logic [4:0] rd, input logic [63:0] data);
        if (rd != 5'd0) begin
            xreg[rd] = data;
            exp_rd.push_back(rd);
            exp_data.push_back(data);
        end
    endtask

    // one issue slot in order with the two slots after a taken branch doing nothing
    task automatic model_step(input logic valid, input logic [31:0] word);
        inst_u       w;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] imm_i;
        logic [63:0] imm_s;
        logic [63:0] imm_b;
        w = word;
        a = xreg[w.r.rs1];
        b = xreg[w.r.rs2];
        imm_i = {{52{w.i.imm[11]}}, w.i.imm};
        imm_s = {{52{w.s.imm_hi[6]}}, w.s.imm_hi, w.s.imm_lo};
        imm_b = {{51{w.b.imm_12}}, w.b.imm_12, w.b.imm_11, w.b.imm_10_5, w.b.imm_4_1, 1'b0};
        if (squash_left > 0) begin
            squash_left--;
        end else if (valid) begin
            case (w.r.opcode)
                OPC_OP, OPC_OP_32:         expect_write(w.r.rd, alu_model(w, a, b));
                OPC_OP_IMM, OPC_OP_IMM_32: expect_write(w.r.rd, alu_model(w, a, imm_i));
                OPC_LOAD:  expect_write(w.r.rd, load_model(a[8:0] + imm_i[8:0], w.r.funct3));
                OPC_STORE: store_model(a[8:0] + imm_s[8:0], w.r.funct3, b);
                OPC_BRANCH: begin
                    if (branch_taken(w.r.funct3, a, b)) begin
                        exp_redirect.push_back(pc + imm_b);
                        squash_left = 2;
                    end
                end
                default: ;
            endcase
        end
    endtask

    task automatic gen_slot(output logic valid, output logic [31:0] word);
        inst_u       w;
        logic [31:0] t;
        logic [31:0] t2;
        logic [31:0] sel;
        logic [4:0]  dest;
        logic [2:0]  f3;
        logic [8:0]  addr;
        logic        alt;
        t = rand32();
        t2 = rand32();
        sel = rand32() % 20;
        w = t;
        valid = 1'b1;
        dest = 5'd0;
        alt = t[2];
        f3 = t[14:12];
        w.r.rs1 = pick_src();
        w.r.rs2 = pick_src();
        if (sel < 2) begin
            // idle slot or a LUI bubble
            valid = t[0];
            w.r.opcode = 7'b0110111;
        end else if (sel < 8) begin
            w.r.opcode = OPC_OP;
            w.r.funct7 = (alt && (f3 == 3'd0 || f3 == 3'd5)) ? FUNCT7_ALT : 7'd0;
            dest = w.r.rd;
        end else if (sel < 11) begin
            w.r.opcode = OPC_OP_IMM;
            if (f3 == 3'd1 || f3 == 3'd5) begin
                w.i.imm[11:6] = (alt && f3 == 3'd5) ? 6'b010000 : 6'd0;
            end
            dest = w.r.rd;
        end else if (sel < 13) begin
            f3 = t[12] ? 3'd1 : (t[13] ? 3'd5 : 3'd0);
            w.r.funct3 = f3;
            if (t[3]) begin
                w.r.opcode = OPC_OP_32;
                w.r.funct7 = (alt && f3 != 3'd1) ? FUNCT7_ALT : 7'd0;
            end else begin
                w.r.opcode = OPC_OP_IMM_32;
                if (f3 != 3'd0) begin
                    w.i.imm[11:5] = (alt && f3 == 3'd5) ? FUNCT7_ALT : 7'd0;
                end
            end
            dest = w.r.rd;
        end else if (sel < 15) begin
            f3 = (f3 == 3'd7) ? F3_D : f3;
            addr = t2[8:0] & ~((9'd1 << f3[1:0]) - 9'd1);
            w.r.opcode = OPC_LOAD;
            w.r.funct3 = f3;
            w.r.rs1 = 5'd0;
            w.i.imm = {3'd0, addr};
            dest = w.r.rd;
        end else if (sel < 17) begin
            f3 = {1'b0, t[13:12]};
            addr = t2[8:0] & ~((9'd1 << f3[1:0]) - 9'd1);
            w = make_store(f3, w.r.rs2, addr);
        end else begin
            w.r.opcode = OPC_BRANCH;
            w.r.funct3 = (f3[2:1] == 2'b01) ? F3_BGE : f3;
            // equal operands now and then
            if (t[1] && t[3]) begin
                w.r.rs2 = w.r.rs1;
            end
        end
        word = w;
        recent_rd[2] = recent_rd[1];
        recent_rd[1] = recent_rd[0];
        recent_rd[0] = dest;
    endtask

    task automatic issue_slot(input logic valid, input logic [31:0] word);
        @(posedge CLK);
        #1;
        inst_valid_i = valid;
        inst_i = word;
        pc_i = pc;
        model_step(valid, word);
        pc = pc + 64'd4;
    endtask

    always @(negedge CLK) begin : monitor
        logic [4:0]  e_rd;
        logic [63:0] e_data;
        if (rst_n_i) begin
            if (wb_en_o !== 1'b0) begin
                if (exp_rd.size() == 0) begin
                    failures++;
                    $display("unexpected register write to x%0d, data %h", wb_rd_o, wb_data_o);
                end else begin
                    e_rd = exp_rd.pop_front();
                    e_data = exp_data.pop_front();
                    check_value("wb_rd_o", {59'd0, wb_rd_o}, {59'd0, e_rd});
                    check_value("wb_data_o", wb_data_o, e_data);
                end
            end
            if (redirect_o !== 1'b0) begin
                if (exp_redirect.size() == 0) begin
                    failures++;
                    $display("unexpected redirect to %h", redirect_pc_o);
                end else begin
                    check_value("redirect_pc_o", redirect_pc_o, exp_redirect.pop_front());
                end
            end
        end
    end

    initial begin
        logic        v;
        logic [31:0] word;
        int          wait_cycles;
        logic        drain_timeout;
        rst_n_i = 1'b0;
        inst_valid_i = 1'b0;
        inst_i = 32'd0;
        pc_i = 64'd0;
        rng = 32'h4ffc;
        pc = 64'h0000_0000_8000_0000;
        squash_left = 0;
        checks = 0;
        mismatches = 0;
        failures = 0;
        drain_timeout = 1'b0;
        for (int i = 0; i < 32; i++) begin
            xreg[i] = 64'd0;
        end
        for (int i = 0; i < DMEM_BYTES; i++) begin
            mem_bytes[i] = 8'd0;
        end
        for (int i = 0; i < 3; i++) begin
            recent_rd[i] = 5'd0;
        end

        repeat (10) @(posedge CLK);
        #1;
        rst_n_i = 1'b1;

        // the data RAM has no reset so doubleword stores of x0 clear it
        for (int i = 0; i < 64; i++) begin
            issue_slot(1'b1, make_store(F3_D, 5'd0, 9'(8 * i)));
        end
        for (int n = 0; n < NUM_SLOTS; n++) begin
            gen_slot(v, word);
            issue_slot(v, word);
        end
        issue_slot(1'b0, 32'd0);

        wait_cycles = 0;
        while ((exp_rd.size() != 0 || exp_redirect.size() != 0) && wait_cycles < 20) begin
            @(posedge CLK);
            wait_cycles++;
        end
        if (exp_rd.size() != 0 || exp_redirect.size() != 0) begin
            drain_timeout = 1'b1;
            $display("timeout: %0d register writes and %0d redirects never appeared",
                     exp_rd.size(), exp_redirect.size());
        end
        // a few idle cycles to catch stray pulses
        repeat (4) @(posedge CLK);

        $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches,
                 failures + (drain_timeout ? 1 : 0));
        if (mismatches == 0 && failures == 0 && !drain_timeout) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- hw/rv_exec_pipe.sv
`timescale 1ns/100ps

module rv_exec_pipe #(
    parameter int DMEM_WORDS = 64
) (
    input  logic        CLK,
    input  logic        rst_n_i,
    input  logic        inst_valid_i,
    input  logic [31:0] inst_i,
    input  logic [63:0] pc_i,
    output logic        wb_en_o,
    output logic [4:0]  wb_rd_o,
    output logic [63:0] wb_data_o,
    output logic        redirect_o,
    output logic [63:0] redirect_pc_o
);

    logic [63:0] rs1_data, rs2_data;
    logic        take_branch;

    // decode to ALU
    logic        d_valid, d_imm, d_word, d_wb, d_load, d_mem_en, d_branch;
    logic [63:0] d_op1, d_op2, d_br_off, d_pc, d_st_val;
    logic [2:0]  d_funct3, d_mem_para;
    logic [6:0]  d_funct7;
    logic [4:0]  d_rd;

    // ALU to memory stage
    logic        a_wb, a_load, a_mem_en, a_branch;
    logic [63:0] a_res, a_br_off, a_pc, a_st_val;
    logic [4:0]  a_rd;
    logic [2:0]  a_mem_para;

    assign redirect_o = take_branch;

    rv_regfile u_regfile (
        .CLK(CLK), .rst_n_i(rst_n_i),
        .rs1_addr_i(inst_i[19:15]), .rs2_addr_i(inst_i[24:20]),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
        .we_i(wb_en_o), .waddr_i(wb_rd_o), .wdata_i(wb_data_o)
    );

    rv_decode u_decode (
        .CLK(CLK), .rst_n_i(rst_n_i), .inst_valid_i(inst_valid_i),
        .inst_i(inst_i), .pc_i(pc_i), .take_branch_i(take_branch),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .valid_o(d_valid), .op1_o(d_op1), .op2_o(d_op2),
        .funct3_o(d_funct3), .funct7_o(d_funct7), .imm_o(d_imm),
        .word_inst_o(d_word), .rd_o(d_rd), .write_back_o(d_wb),
        .load_flag_o(d_load), .mem_en_o(d_mem_en), .mem_para_o(d_mem_para),
        .branch_flag_o(d_branch), .branch_offset_o(d_br_off),
        .pc_o(d_pc), .store_value_o(d_st_val)
    );

    rv_alu u_alu (
        .CLK(CLK), .rst_n_i(rst_n_i), .take_branch_i(take_branch),
        .valid_i(d_valid), .op1_i(d_op1), .op2_i(d_op2),
        .funct3_i(d_funct3), .funct7_i(d_funct7), .imm_i(d_imm),
        .word_inst_i(d_word), .rd_i(d_rd), .write_back_i(d_wb),
        .load_flag_i(d_load), .mem_en_i(d_mem_en), .mem_para_i(d_mem_para),
        .branch_flag_i(d_branch), .branch_offset_i(d_br_off),
        .pc_i(d_pc), .store_value_i(d_st_val),
        .res_o(a_res), .write_back_o(a_wb), .rd_o(a_rd),
        .load_flag_o(a_load), .mem_en_o(a_mem_en), .mem_para_o(a_mem_para),
        .branch_flag_o(a_branch), .branch_offset_o(a_br_off),
        .pc_o(a_pc), .store_value_o(a_st_val)
    );

    rv_mem_stage #(
        .DMEM_WORDS(DMEM_WORDS)
    ) u_mem_stage (
        .CLK(CLK), .rst_n_i(rst_n_i),
        .res_i(a_res), .write_back_i(a_wb), .rd_i(a_rd),
        .load_flag_i(a_load), .mem_en_i(a_mem_en), .mem_para_i(a_mem_para),
        .branch_flag_i(a_branch), .branch_offset_i(a_br_off),
        .pc_i(a_pc), .store_value_i(a_st_val),
        .take_branch_o(take_branch), .redirect_pc_o(redirect_pc_o),
        .wb_en_o(wb_en_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o)
    );

endmodule

//--- hw/rv_mem_stage.sv
`timescale 1ns/100ps

module rv_mem_stage
    import rv64_pkg::*;
#(
    parameter int DMEM_WORDS = 64
) (
    input  logic        CLK,
    input  logic        rst_n_i,
    input  logic [63:0] res_i,
    input  logic        write_back_i,
    input  logic [4:0]  rd_i,
    input  logic        load_flag_i,
    input  logic        mem_en_i,
    input  logic [2:0]  mem_para_i,
    input  logic        branch_flag_i,
    input  logic [63:0] branch_offset_i,
    input  logic [63:0] pc_i,
    input  logic [63:0] store_value_i,
    output logic        take_branch_o,
    output logic [63:0] redirect_pc_o,
    output logic        wb_en_o,
    output logic [4:0]  wb_rd_o,
    output logic [63:0] wb_data_o
);

    localparam int AW = $clog2(DMEM_WORDS);

    logic [63:0]   dmem [DMEM_WORDS];
    logic [AW-1:0] idx;
    logic [5:0]    bit_off;
    logic [63:0]   rd_word, ld_shift, ld_val;
    logic [63:0]   size_mask, st_mask, st_data;

    assign take_branch_o = branch_flag_i && res_i[0];
    assign redirect_pc_o = pc_i + branch_offset_i;

    // index wraps on the low address bits
    assign idx     = res_i[AW+2:3];
    assign bit_off = {res_i[2:0], 3'b000};
    assign rd_word = dmem[idx];

    assign ld_shift = rd_word >> bit_off;

    always_comb begin
        case (mem_para_i)
            F3_B:    ld_val = {{56{ld_shift[7]}}, ld_shift[7:0]};
            F3_H:    ld_val = {{48{ld_shift[15]}}, ld_shift[15:0]};
            F3_W:    ld_val = {{32{ld_shift[31]}}, ld_shift[31:0]};
            F3_BU:   ld_val = {56'd0, ld_shift[7:0]};
            F3_HU:   ld_val = {48'd0, ld_shift[15:0]};
            F3_WU:   ld_val = {32'd0, ld_shift[31:0]};
            F3_D:    ld_val = ld_shift;
            default: ld_val = ld_shift;
        endcase
    end

    always_comb begin
        case (mem_para_i)
            F3_B:    size_mask = 64'h0000_0000_0000_00ff;
            F3_H:    size_mask = 64'h0000_0000_0000_ffff;
            F3_W:    size_mask = 64'h0000_0000_ffff_ffff;
            default: size_mask = '1;
        endcase
    end

    assign st_mask = size_mask << bit_off;
    assign st_data = store_value_i << bit_off;

    // read-modify-write of the addressed lanes
    always_ff @(posedge CLK) begin
        if (mem_en_i && !load_flag_i) begin
            dmem[idx] <= (rd_word & ~st_mask) | (st_data & st_mask);
        end
    end

    always_ff @(posedge CLK) begin
        wb_data_o <= (mem_en_i && load_flag_i) ? ld_val : res_i;
        if (!rst_n_i) begin
            wb_en_o <= 1'b0;
            wb_rd_o <= 5'd0;
        end else begin
            wb_en_o <= write_back_i;
            wb_rd_o <= rd_i;
        end
    end

    a_mem_not_branch: assert property (@(posedge CLK) disable iff (!rst_n_i)
        !(mem_en_i && branch_flag_i));

endmodule

//--- hw/rv_alu.sv
`timescale 1ns/100ps

module rv_alu
    import rv64_pkg::*;
(
    input  logic        CLK,
    input  logic        rst_n_i,
    input  logic        take_branch_i,
    input  logic        valid_i,
    input  logic [63:0] op1_i,
    input  logic [63:0] op2_i,
    input  logic [2:0]  funct3_i,
    input  logic [6:0]  funct7_i,
    input  logic        imm_i,
    input  logic        word_inst_i,
    input  logic [4:0]  rd_i,
    input  logic        write_back_i,
    input  logic        load_flag_i,
    input  logic        mem_en_i,
    input  logic [2:0]  mem_para_i,
    input  logic        branch_flag_i,
    input  logic [63:0] branch_offset_i,
    input  logic [63:0] pc_i,
    input  logic [63:0] store_value_i,
    output logic [63:0] res_o,
    output logic        write_back_o,
    output logic [4:0]  rd_o,
    output logic        load_flag_o,
    output logic        mem_en_o,
    output logic [2:0]  mem_para_o,
    output logic        branch_flag_o,
    output logic [63:0] branch_offset_o,
    output logic [63:0] pc_o,
    output logic [63:0] store_value_o
);

    logic        alt;
    logic [63:0] addsub, sra64, alu_res;
    logic [31:0] sll32, srl32, sra32;
    logic        br_cond;

    function automatic logic [63:0] sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    assign alt    = funct7_i == FUNCT7_ALT;
    // immediates never select SUB
    assign addsub = (alt && !imm_i) ? op1_i - op2_i : op1_i + op2_i;
    assign sra64  = $signed(op1_i) >>> op2_i[5:0];
    assign sll32  = op1_i[31:0] << op2_i[4:0];
    assign srl32  = op1_i[31:0] >> op2_i[4:0];
    assign sra32  = $signed(op1_i[31:0]) >>> op2_i[4:0];

    always_comb begin
        case (funct3_i)
            3'b000:  alu_res = word_inst_i ? sext32(addsub[31:0]) : addsub;
            3'b001:  alu_res = word_inst_i ? sext32(sll32) : op1_i << op2_i[5:0];
            3'b010:  alu_res = {63'd0, $signed(op1_i) < $signed(op2_i)};
            3'b011:  alu_res = {63'd0, op1_i < op2_i};
            3'b100:  alu_res = op1_i ^ op2_i;
            3'b101: begin
                if (word_inst_i) begin
                    alu_res = alt ? sext32(sra32) : sext32(srl32);
                end else begin
                    alu_res = alt ? sra64 : op1_i >> op2_i[5:0];
                end
            end
            3'b110:  alu_res = op1_i | op2_i;
            default: alu_res = op1_i & op2_i;
        endcase
    end

    always_comb begin
        case (funct3_i)
            F3_BEQ:  br_cond = op1_i == op2_i;
            F3_BNE:  br_cond = op1_i != op2_i;
            F3_BLT:  br_cond = $signed(op1_i) < $signed(op2_i);
            F3_BGE:  br_cond = $signed(op1_i) >= $signed(op2_i);
            F3_BLTU: br_cond = op1_i < op2_i;
            F3_BGEU: br_cond = op1_i >= op2_i;
            default: br_cond = 1'b0;
        endcase
    end

    always_ff @(posedge CLK) begin
        res_o <= branch_flag_i ? {63'd0, br_cond} : alu_res;
        load_flag_o <= load_flag_i;
        mem_para_o <= mem_para_i;
        branch_offset_o <= branch_offset_i;
        pc_o <= pc_i;
        store_value_o <= store_value_i;

        if (!rst_n_i || take_branch_i) begin
            // squash the younger instruction
            write_back_o <= 1'b0;
            rd_o <= 5'd0;
            mem_en_o <= 1'b0;
            branch_flag_o <= 1'b0;
        end else begin
            write_back_o <= write_back_i;
            rd_o <= rd_i;
            mem_en_o <= mem_en_i;
            branch_flag_o <= branch_flag_i && valid_i;
        end
    end

    a_branch_no_wb: assert property (@(posedge CLK) disable iff (!rst_n_i)
        !(branch_flag_o && write_back_o));

endmodule

//--- hw/rv_decode.sv
`timescale 1ns/100ps

module rv_decode
    import rv64_pkg::*;
(
    input  logic        CLK,
    input  logic        rst_n_i,
    input  logic        inst_valid_i,
    input  logic [31:0] inst_i,
    input  logic [63:0] pc_i,
    input  logic        take_branch_i,
    input  logic [63:0] rs1_data_i,
    input  logic [63:0] rs2_data_i,
    output logic        valid_o,
    output logic [63:0] op1_o,
    output logic [63:0] op2_o,
    output logic [2:0]  funct3_o,
    output logic [6:0]  funct7_o,
    output logic        imm_o,
    output logic        word_inst_o,
    output logic [4:0]  rd_o,
    output logic        write_back_o,
    output logic        load_flag_o,
    output logic        mem_en_o,
    output logic [2:0]  mem_para_o,
    output logic        branch_flag_o,
    output logic [63:0] branch_offset_o,
    output logic [63:0] pc_o,
    output logic [63:0] store_value_o
);

    inst_u       iw;
    logic        is_op, is_op_imm, is_op_32, is_op_imm_32;
    logic        is_load, is_store, is_branch;
    logic        accept;
    logic [63:0] imm_i_ext, imm_s_ext, imm_b_ext;

    assign iw = inst_i;

    assign is_op        = iw.r.opcode == OPC_OP;
    assign is_op_imm    = iw.r.opcode == OPC_OP_IMM;
    assign is_op_32     = iw.r.opcode == OPC_OP_32;
    assign is_op_imm_32 = iw.r.opcode == OPC_OP_IMM_32;
    assign is_load      = iw.r.opcode == OPC_LOAD;
    assign is_store     = iw.r.opcode == OPC_STORE;
    assign is_branch    = iw.r.opcode == OPC_BRANCH;

    // unknown opcodes and squashed words become bubbles
    assign accept = inst_valid_i && !take_branch_i && (is_op || is_op_imm || is_op_32
                    || is_op_imm_32 || is_load || is_store || is_branch);

    assign imm_i_ext = {{52{iw.i.imm[11]}}, iw.i.imm};
    assign imm_s_ext = {{52{iw.s.imm_hi[6]}}, iw.s.imm_hi, iw.s.imm_lo};
    assign imm_b_ext = {{51{iw.b.imm_12}}, iw.b.imm_12, iw.b.imm_11,
                        iw.b.imm_10_5, iw.b.imm_4_1, 1'b0};

    always_ff @(posedge CLK) begin
        op1_o <= rs1_data_i;
        if (is_op || is_op_32 || is_branch) begin
            op2_o <= rs2_data_i;
        end else if (is_store) begin
            op2_o <= imm_s_ext;
        end else begin
            op2_o <= imm_i_ext;
        end
        // address calc uses the adder and the size goes to mem_para
        funct3_o <= (is_load || is_store) ? 3'b000 : iw.r.funct3;
        // bit 25 is shamt[5] for 64-bit immediate shifts
        funct7_o <= is_op_imm ? {iw.r.funct7[6:1], 1'b0} : iw.r.funct7;
        imm_o <= is_op_imm || is_op_imm_32 || is_load || is_store;
        word_inst_o <= is_op_32 || is_op_imm_32;
        rd_o <= iw.r.rd;
        load_flag_o <= is_load;
        mem_para_o <= iw.r.funct3;
        branch_offset_o <= imm_b_ext;
        pc_o <= pc_i;
        store_value_o <= rs2_data_i;

        if (!rst_n_i) begin
            valid_o <= 1'b0;
            write_back_o <= 1'b0;
            mem_en_o <= 1'b0;
            branch_flag_o <= 1'b0;
        end else begin
            valid_o <= accept;
            write_back_o <= accept && iw.r.rd != 5'd0
                            && (is_op || is_op_imm || is_op_32 || is_op_imm_32 || is_load);
            mem_en_o <= accept && (is_load || is_store);
            branch_flag_o <= accept && is_branch;
        end
    end

endmodule

//--- hw/rv_regfile.sv
`timescale 1ns/100ps

module rv_regfile (
    input  logic        CLK,
    input  logic        rst_n_i,
    input  logic [4:0]  rs1_addr_i,
    input  logic [4:0]  rs2_addr_i,
    output logic [63:0] rs1_data_o,
    output logic [63:0] rs2_data_o,
    input  logic        we_i,
    input  logic [4:0]  waddr_i,
    input  logic [63:0] wdata_i
);

    logic [63:0] regs [1:31];

    // a register being written reads as the new value
    function automatic logic [63:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return 64'd0;
        end
        if (we_i && waddr_i == addr) begin
            return wdata_i;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

    always_ff @(posedge CLK) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 64'd0;
            end
        end else if (we_i && waddr_i != 5'd0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // decode never enables write-back for rd = x0
    a_no_x0_write: assert property (@(posedge CLK) disable iff (!rst_n_i)
        we_i |-> waddr_i != 5'd0);

endmodule

//--- hw/rv64_pkg.sv
package rv64_pkg;

    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;

    // selects SUB and SRA/SRAI
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // load/store sizes with the upper bit selecting zero extension
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_D  = 3'b011;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;
    localparam logic [2:0] F3_WU = 3'b110;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
    } inst_u;

endpackage
